// File: flist.f
verilog/mon_char_pkg.sv
verilog/mon_cmd_pkg.sv
verilog/mon_char_decode.sv
verilog/mon_word_assembler.sv
verilog/mon_cmd_fsm.sv
verilog/uart_monitor.sv
test/tb_uart_monitor_assert.sv
test/tb_uart_monitor.sv

// File: Makefile
# Verilator simulation of the uart monitor testbench
TOP := tb_uart_monitor
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_uart_monitor.sv
// testbench for uart_monitor; words from $random with seed 8, GO_START_DELAY fixed at 3
`default_nettype none

module tb_uart_monitor;

	localparam int GO_START_DELAY = 3;
	// up to 20 tests of about 100 cycles each
	localparam int TIMEOUT_CYCLES = 20 * 100;

	logic                      clk = 1'b0;
	logic                      rst_n;
	mon_char_pkg::char_t       rout;
	logic                      rout_en;
	mon_cmd_pkg::ctrl_status_t status;
	mon_cmd_pkg::word_t        uart_data;
	mon_cmd_pkg::mon_strobes_t strobes;

	// expected strobe events in order, with the word each one carries
	mon_cmd_pkg::mon_strobes_t exp_ev[$];
	mon_cmd_pkg::word_t        exp_data[$];
	// compare process state
	mon_cmd_pkg::mon_strobes_t ev;
	mon_cmd_pkg::mon_strobes_t ev_exp;
	mon_cmd_pkg::word_t        data_exp;
	bit                        cmp_bad;
	int                        cycle_cnt = 0;
	int                        crlf_cycle = 0;
	// error counts, one per process
	int                        run_errors = 0;
	int                        cmp_errors = 0;
	int                        tests = 0;
	int                        failed_tests = 0;
	int                        errors_at_start = 0;
	string                     test_name;
	integer                    seed = 8;

	uart_monitor #(
		.GO_START_DELAY (GO_START_DELAY)
	) uart_monitor_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.rout      (rout),
		.rout_en   (rout_en),
		.status    (status),
		.uart_data (uart_data),
		.strobes   (strobes)
	);

	bind mon_cmd_fsm tb_uart_monitor_assert tb_uart_monitor_assert_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.state   (state),
		.strobes (strobes)
	);

	always #50 clk = ~clk;

	// cycle count and run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout, tests still running after %0d cycles", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_word(input string name, input mon_cmd_pkg::word_t got,
		input mon_cmd_pkg::word_t exp, output bit bad);
		bad = (got !== exp);
		if (bad) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_strobe(input string name, input mon_cmd_pkg::mon_strobes_t got,
		input mon_cmd_pkg::mon_strobes_t exp, output bit bad);
		bad = (got !== exp);
		if (bad) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp,
		output bit bad);
		bad = (got != exp);
		if (bad) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// eight lowercase hex characters, most significant digit in the top byte
	function automatic logic [63:0] fmt_hex(input mon_cmd_pkg::word_t w);
		logic [63:0]           chars;
		mon_char_pkg::nibble_t n;
		for (int i = 0; i < 8; i++) begin
			n = w[i*4 +: 4];
			chars[i*8 +: 8] = (n < 4'd10) ? (8'h30 + 8'(n)) : (8'h61 + 8'(n) - 8'd10);
		end
		return chars;
	endfunction

	// reference word of a character stream
	// lowercase digits shift in msd first, q clears, all else is ignored
	function automatic mon_cmd_pkg::word_t ref_word(input mon_char_pkg::char_t seq[$]);
		mon_cmd_pkg::word_t acc;
		logic [7:0]         v;
		acc = '0;
		foreach (seq[i]) begin
			if (seq[i] >= 8'h30 && seq[i] <= 8'h39) begin
				v   = seq[i] - 8'h30;
				acc = {acc[27:0], v[3:0]};
			end else if (seq[i] >= 8'h61 && seq[i] <= 8'h66) begin
				v   = seq[i] - 8'h61 + 8'd10;
				acc = {acc[27:0], v[3:0]};
			end else if (seq[i] == 8'h71) begin
				acc = '0;
			end
		end
		return acc;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// one-cycle strobe, next character six cycles later
	task automatic send_char(input mon_char_pkg::char_t c);
		@(posedge clk);
		#10;
		rout    = c;
		rout_en = 1'b1;
		@(posedge clk);
		#10;
		rout_en = 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic send_word(input mon_cmd_pkg::word_t w);
		logic [63:0] chars;
		chars = fmt_hex(w);
		for (int i = 7; i >= 0; i--) begin
			send_char(chars[i*8 +: 8]);
		end
	endtask

	task automatic set_status(input logic dump, input logic trush);
		@(posedge clk);
		#10;
		status.dump_running  = dump;
		status.trush_running = trush;
	endtask

	// data is only compared for address and data strobes
	task automatic expect_ev(input mon_cmd_pkg::mon_strobes_t s, input mon_cmd_pkg::word_t d);
		exp_ev.push_back(s);
		exp_data.push_back(d);
	endtask

	task automatic start_test(input string name);
		tests++;
		test_name       = name;
		errors_at_start = run_errors + cmp_errors;
	endtask

	task automatic end_test();
		// let trailing strobes arrive
		wait_cycles(6);
		if (exp_ev.size() != 0) begin
			$display("%0d expected strobe events never arrived", exp_ev.size());
			run_errors++;
			exp_ev.delete();
			exp_data.delete();
		end
		if (run_errors + cmp_errors != errors_at_start) begin
			failed_tests++;
			$display("test %0d %s: FAILED", tests, test_name);
		end else begin
			$display("test %0d %s: ok", tests, test_name);
		end
	endtask

	// compare process, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			ev = strobes;
			// select is a level, checked by the print test
			ev.pc_print_sel = 1'b0;
			if (ev != '0) begin
				if (exp_ev.size() == 0) begin
					$display("unexpected strobes %h in cycle %0d", ev, cycle_cnt);
					cmp_errors++;
				end else begin
					ev_exp   = exp_ev.pop_front();
					data_exp = exp_data.pop_front();
					check_strobe("strobes", ev, ev_exp, cmp_bad);
					cmp_errors += int'(cmp_bad);
					if (ev_exp.write_address_set | ev_exp.write_data_en
						| ev_exp.read_start_set | ev_exp.read_end_set) begin
						check_word("uart_data", uart_data, data_exp, cmp_bad);
						cmp_errors += int'(cmp_bad);
					end
				end
				if (ev.crlf_in) begin
					crlf_cycle = cycle_cnt;
				end
				// go line feed to cpu_start
				if (ev.cpu_start) begin
					check_count("cpu_start delay", cycle_cnt - crlf_cycle, GO_START_DELAY, cmp_bad);
					cmp_errors += int'(cmp_bad);
				end
			end
		end
	end

	initial begin
		mon_cmd_pkg::word_t  w0;
		mon_cmd_pkg::word_t  w1;
		mon_cmd_pkg::word_t  w2;
		logic [63:0]         chars;
		mon_char_pkg::char_t seq[$];
		bit                  bad;
		int                  i;
		rst_n   = 1'b0;
		rout    = '0;
		rout_en = 1'b0;
		status  = '0;
		wait_cycles(2);
		#10;
		rst_n = 1'b1;

		// address, two data words, quit
		start_test("write");
		w0 = $random(seed);
		w1 = $random(seed);
		w2 = $random(seed);
		expect_ev('{write_address_set: 1'b1, crlf_in: 1'b1, default: 1'b0}, w0);
		expect_ev('{write_data_en: 1'b1, default: 1'b0}, w1);
		expect_ev('{write_data_en: 1'b1, default: 1'b0}, w2);
		expect_ev('{quit_cmd: 1'b1, default: 1'b0}, '0);
		send_char(mon_char_pkg::CH_WRITE);
		send_word(w0);
		send_word(w1);
		send_word(w2);
		send_char(mon_char_pkg::CH_QUIT);
		end_test();

		// first dump stopped by q, second ends on its own
		start_test("read");
		w0 = $random(seed);
		w1 = $random(seed);
		set_status(1'b1, 1'b0);
		expect_ev('{read_start_set: 1'b1, default: 1'b0}, w0);
		expect_ev('{read_end_set: 1'b1, crlf_in: 1'b1, default: 1'b0}, w1);
		expect_ev('{read_stop: 1'b1, quit_cmd: 1'b1, default: 1'b0}, '0);
		send_char(mon_char_pkg::CH_READ);
		send_word(w0);
		send_word(w1);
		send_char(mon_char_pkg::CH_QUIT);
		w0 = $random(seed);
		w1 = $random(seed);
		expect_ev('{read_start_set: 1'b1, default: 1'b0}, w0);
		expect_ev('{read_end_set: 1'b1, crlf_in: 1'b1, default: 1'b0}, w1);
		expect_ev('{start_trush: 1'b1, crlf_in: 1'b1, default: 1'b0}, '0);
		send_char(mon_char_pkg::CH_READ);
		send_word(w0);
		send_word(w1);
		set_status(1'b0, 1'b0);
		wait_cycles(2);
		send_char(mon_char_pkg::CH_TRASH);
		end_test();

		// digits after the go address start nothing
		start_test("go");
		w0 = $random(seed);
		w1 = $random(seed);
		expect_ev('{crlf_in: 1'b1, default: 1'b0}, '0);
		expect_ev('{cpu_start: 1'b1, default: 1'b0}, '0);
		expect_ev('{quit_cmd: 1'b1, default: 1'b0}, '0);
		send_char(mon_char_pkg::CH_GO);
		send_word(w0);
		send_word(w1);
		send_char(mon_char_pkg::CH_QUIT);
		end_test();

		// w is ignored until trash is done
		start_test("trash");
		w0 = $random(seed);
		w1 = $random(seed);
		set_status(1'b0, 1'b1);
		expect_ev('{start_trush: 1'b1, crlf_in: 1'b1, default: 1'b0}, '0);
		expect_ev('{write_address_set: 1'b1, crlf_in: 1'b1, default: 1'b0}, w1);
		expect_ev('{quit_cmd: 1'b1, default: 1'b0}, '0);
		send_char(mon_char_pkg::CH_TRASH);
		send_char(mon_char_pkg::CH_WRITE);
		send_word(w0);
		set_status(1'b0, 1'b0);
		wait_cycles(2);
		send_char(mon_char_pkg::CH_WRITE);
		send_word(w1);
		send_char(mon_char_pkg::CH_QUIT);
		end_test();

		// select held while the dump engine runs
		start_test("print");
		set_status(1'b1, 1'b0);
		expect_ev('{pc_print: 1'b1, crlf_in: 1'b1, default: 1'b0}, '0);
		send_char(mon_char_pkg::CH_PC);
		wait_cycles(2);
		@(negedge clk);
		check_strobe("strobes", strobes, '{pc_print_sel: 1'b1, default: 1'b0}, bad);
		run_errors += int'(bad);
		set_status(1'b0, 1'b0);
		wait_cycles(2);
		@(negedge clk);
		check_strobe("strobes", strobes, '0, bad);
		run_errors += int'(bad);
		end_test();

		// partial word dropped by q, uppercase A inside the next word
		start_test("abort");
		w0    = $random(seed);
		chars = fmt_hex(w0);
		seq   = {mon_char_pkg::CH_WRITE, 8'h31, 8'h32, 8'h33, mon_char_pkg::CH_QUIT,
			mon_char_pkg::CH_WRITE};
		for (i = 7; i >= 0; i--) begin
			seq.push_back(chars[i*8 +: 8]);
			if (i == 4) begin
				seq.push_back(8'h41);
			end
		end
		expect_ev('{quit_cmd: 1'b1, default: 1'b0}, '0);
		expect_ev('{write_address_set: 1'b1, crlf_in: 1'b1, default: 1'b0}, ref_word(seq));
		expect_ev('{quit_cmd: 1'b1, default: 1'b0}, '0);
		foreach (seq[k]) begin
			send_char(seq[k]);
		end
		send_char(mon_char_pkg::CH_QUIT);
		end_test();

		$display("%0d tests, %0d failed, %0d check errors", tests, failed_tests,
			run_errors + cmp_errors);
		if (run_errors + cmp_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tb_uart_monitor_assert.sv
// strobe rules of the command FSM, bound to mon_cmd_fsm; sampled on the rising clock edge
`default_nettype none

module tb_uart_monitor_assert (
	input wire                        clk,
	input wire                        rst_n,
	input mon_cmd_pkg::cmd_state_e    state,
	input mon_cmd_pkg::mon_strobes_t  strobes
);

	// go start is a single pulse
	cpu_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		strobes.cpu_start |=> !strobes.cpu_start)
		else $error("cpu_start high for more than one cycle");

	// quit lasts one cycle
	quit_cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		strobes.quit_cmd |=> !strobes.quit_cmd)
		else $error("quit_cmd high for more than one cycle");

	// at most one address, data or command strobe
	cmd_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({strobes.write_address_set, strobes.write_data_en,
			strobes.read_start_set, strobes.read_end_set,
			strobes.start_trush, strobes.quit_cmd, strobes.pc_print}))
		else $error("more than one address, data or command strobe at once");

	// select comes up only after a pc print command in idle
	pc_sel_entry: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(strobes.pc_print_sel)
		|-> $past(strobes.pc_print && (state == mon_cmd_pkg::ST_IDLE)))
		else $error("pc_print_sel rose without a pc_print command in idle");

endmodule

`default_nettype wire

// File: verilog/uart_monitor.sv
// monitor character front end; no back-pressure, bytes at least two cycles apart
`default_nettype none

module uart_monitor #(
	// cycles from the go line feed to cpu_start
	parameter int GO_START_DELAY = 3
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  mon_char_pkg::char_t       rout,
	input  wire                       rout_en,
	input  mon_cmd_pkg::ctrl_status_t status,
	output mon_cmd_pkg::word_t        uart_data,
	output mon_cmd_pkg::mon_strobes_t strobes
);

	// decoded character to both later stages
	mon_char_pkg::char_info_t info;
	// fsm to assembler
	logic                     collect;
	logic                     word_start;
	logic                     abort;
	// assembler back to fsm
	logic                     word_valid;

	mon_char_decode mon_char_decode_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.rout    (rout),
		.rout_en (rout_en),
		.info    (info)
	);

	mon_word_assembler mon_word_assembler_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.info       (info),
		.collect    (collect),
		.word_start (word_start),
		.abort      (abort),
		.word_valid (word_valid),
		.word       (uart_data)
	);

	mon_cmd_fsm #(
		.GO_START_DELAY (GO_START_DELAY)
	) mon_cmd_fsm_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.info       (info),
		.status     (status),
		.word_valid (word_valid),
		.collect    (collect),
		.word_start (word_start),
		.abort      (abort),
		.strobes    (strobes)
	);

endmodule

`default_nettype wire

// File: verilog/mon_cmd_fsm.sv
// command FSM; strobes are combinational, status levels are assumed steady, GO_START_DELAY >= 1
`default_nettype none

module mon_cmd_fsm #(
	parameter int GO_START_DELAY = 3
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  mon_char_pkg::char_info_t   info,
	input  mon_cmd_pkg::ctrl_status_t  status,
	input  wire                        word_valid,
	output logic                       collect,
	output logic                       word_start,
	output logic                       abort,
	output mon_cmd_pkg::mon_strobes_t  strobes
);

	mon_cmd_pkg::cmd_state_e state;
	mon_cmd_pkg::cmd_state_e next_state;
	logic                    cmd_g;
	logic                    cmd_q;
	logic                    cmd_w;
	logic                    cmd_r;
	logic                    cmd_t;
	logic                    cmd_j;
	logic                    cmd_cr;
	logic                    idle;
	logic                    g_crlf;
	logic                    w_crlf;
	logic                    r_crlf;
	logic [GO_START_DELAY-1:0] go_dly;

	// one-cycle command events
	assign cmd_g  = info.valid & (info.cmd == mon_char_pkg::CMD_GO);
	assign cmd_q  = info.valid & (info.cmd == mon_char_pkg::CMD_QUIT);
	assign cmd_w  = info.valid & (info.cmd == mon_char_pkg::CMD_WRITE);
	assign cmd_r  = info.valid & (info.cmd == mon_char_pkg::CMD_READ);
	assign cmd_t  = info.valid & (info.cmd == mon_char_pkg::CMD_TRASH);
	assign cmd_j  = info.valid & (info.cmd == mon_char_pkg::CMD_PC);
	assign cmd_cr = info.valid & (info.cmd == mon_char_pkg::CMD_CR);

	always_comb begin
		next_state = state;
		if (cmd_q) begin
			// quit wins everywhere
			next_state = mon_cmd_pkg::ST_IDLE;
		end else begin
			case (state)
				mon_cmd_pkg::ST_IDLE: begin
					// j first, then g, w, r, t
					if (cmd_j)      next_state = mon_cmd_pkg::ST_PC_PRINT;
					else if (cmd_g) next_state = mon_cmd_pkg::ST_GO_ADDR;
					else if (cmd_w) next_state = mon_cmd_pkg::ST_WR_ADDR;
					else if (cmd_r) next_state = mon_cmd_pkg::ST_RD_START;
					else if (cmd_t) next_state = mon_cmd_pkg::ST_TRASH;
				end
				mon_cmd_pkg::ST_GO_ADDR:
					if (word_valid) next_state = mon_cmd_pkg::ST_GO_RUN;
				mon_cmd_pkg::ST_WR_ADDR:
					if (word_valid) next_state = mon_cmd_pkg::ST_WR_DATA;
				mon_cmd_pkg::ST_RD_START:
					if (word_valid) next_state = mon_cmd_pkg::ST_RD_END;
				mon_cmd_pkg::ST_RD_END:
					if (word_valid) next_state = mon_cmd_pkg::ST_RD_DUMP;
				// dump and pc print both run on the dump engine
				mon_cmd_pkg::ST_RD_DUMP, mon_cmd_pkg::ST_PC_PRINT:
					if (!status.dump_running) next_state = mon_cmd_pkg::ST_IDLE;
				mon_cmd_pkg::ST_TRASH:
					if (!status.trush_running) next_state = mon_cmd_pkg::ST_IDLE;
				// go_run and wr_data leave only on quit
				default: next_state = state;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mon_cmd_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	assign idle = (state == mon_cmd_pkg::ST_IDLE);

	// word-completing transitions that answer with a line feed
	assign g_crlf = (state == mon_cmd_pkg::ST_GO_ADDR) & (next_state == mon_cmd_pkg::ST_GO_RUN);
	assign w_crlf = (state == mon_cmd_pkg::ST_WR_ADDR) & (next_state == mon_cmd_pkg::ST_WR_DATA);
	assign r_crlf = (state == mon_cmd_pkg::ST_RD_END) & (next_state == mon_cmd_pkg::ST_RD_DUMP);

	// word assembler control
	assign collect = (state == mon_cmd_pkg::ST_GO_ADDR) | (state == mon_cmd_pkg::ST_WR_ADDR)
		| (state == mon_cmd_pkg::ST_WR_DATA) | (state == mon_cmd_pkg::ST_RD_START)
		| (state == mon_cmd_pkg::ST_RD_END);
	assign word_start = idle & ((next_state == mon_cmd_pkg::ST_GO_ADDR)
		| (next_state == mon_cmd_pkg::ST_WR_ADDR) | (next_state == mon_cmd_pkg::ST_RD_START));
	assign abort = cmd_q;

	// go line feed delayed into cpu_start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			go_dly <= '0;
		end else begin
			go_dly[0] <= g_crlf;
			for (int i = 1; i < GO_START_DELAY; i++) begin
				go_dly[i] <= go_dly[i-1];
			end
		end
	end

	always_comb begin
		strobes.write_address_set = (state == mon_cmd_pkg::ST_WR_ADDR) & word_valid;
		strobes.write_data_en     = (state == mon_cmd_pkg::ST_WR_DATA) & word_valid;
		strobes.read_start_set    = (state == mon_cmd_pkg::ST_RD_START) & word_valid;
		strobes.read_end_set      = (state == mon_cmd_pkg::ST_RD_END) & word_valid;
		// quit during a dump stops it
		strobes.read_stop         = (state == mon_cmd_pkg::ST_RD_DUMP) & cmd_q;
		strobes.start_trush       = idle & cmd_t;
		strobes.quit_cmd          = cmd_q;
		strobes.pc_print          = idle & (next_state == mon_cmd_pkg::ST_PC_PRINT);
		strobes.pc_print_sel      = (state == mon_cmd_pkg::ST_PC_PRINT);
		strobes.crlf_in           = g_crlf | w_crlf | r_crlf | (idle & (cmd_q | cmd_t | cmd_j))
			| cmd_cr;
		strobes.cpu_start         = go_dly[GO_START_DELAY-1];
	end

endmodule

`default_nettype wire

// File: verilog/mon_word_assembler.sv
// builds 32-bit words from eight hex digits, msd first; counter needs one idle cycle per word
`default_nettype none

module mon_word_assembler (
	input  wire                      clk,
	input  wire                      rst_n,
	input  mon_char_pkg::char_info_t info,
	input  wire                      collect,
	input  wire                      word_start,
	input  wire                      abort,
	output logic                     word_valid,
	output mon_cmd_pkg::word_t       word
);

	localparam int CNT_W  = $clog2(mon_cmd_pkg::WORD_DIGITS + 1);
	localparam int WORD_W = $bits(mon_cmd_pkg::word_t);
	localparam int NIB_W  = $bits(mon_char_pkg::nibble_t);

	mon_cmd_pkg::word_t shift_q;
	logic [CNT_W-1:0]   digit_cnt;
	logic               accept;
	logic               last_digit;
	mon_cmd_pkg::word_t shift_next;

	// digit taken only while an address or data word is expected
	assign accept     = info.valid & info.is_digit & collect;
	assign last_digit = accept & (digit_cnt == CNT_W'(mon_cmd_pkg::WORD_DIGITS - 1));
	assign shift_next = {shift_q[WORD_W-NIB_W-1:0], info.nibble};

	// partial word
	always_ff @(posedge clk) begin
		if (abort) begin
			shift_q <= '0;
		end else if (accept) begin
			shift_q <= shift_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_cnt <= '0;
		end else if (word_start || abort) begin
			digit_cnt <= '0;
		end else if (digit_cnt == CNT_W'(mon_cmd_pkg::WORD_DIGITS)) begin
			// full word seen, spend one cycle clearing
			digit_cnt <= '0;
		end else if (accept) begin
			digit_cnt <= digit_cnt + 1'b1;
		end
	end

	// finished word, held until the next one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word       <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= last_digit;
			if (last_digit) begin
				word <= shift_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mon_char_decode.sv
// captures each received byte; bytes must arrive at least two cycles apart
`default_nettype none

module mon_char_decode (
	input  wire                      clk,
	input  wire                      rst_n,
	input  mon_char_pkg::char_t      rout,
	input  wire                      rout_en,
	output mon_char_pkg::char_info_t info
);

	// held copy of the last byte
	mon_char_pkg::char_t char_q;
	// strobe delayed to line up with char_q
	logic                valid_q;

	always_ff @(posedge clk) begin
		if (rout_en) begin
			char_q <= rout;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= rout_en;
		end
	end

	// classify the held byte
	always_comb begin
		info.valid    = valid_q;
		info.is_digit = 1'b0;
		info.nibble   = '0;
		info.cmd      = mon_char_pkg::CMD_NONE;
		if (char_q >= mon_char_pkg::CH_DIGIT_0 && char_q <= mon_char_pkg::CH_DIGIT_9) begin
			// '0'..'9' carry their value in the low nibble
			info.is_digit = 1'b1;
			info.nibble   = char_q[3:0];
		end else if (char_q >= mon_char_pkg::CH_HEX_A && char_q <= mon_char_pkg::CH_HEX_F) begin
			// 'a' has low nibble 1, so add 9
			info.is_digit = 1'b1;
			info.nibble   = char_q[3:0] + 4'd9;
		end else begin
			case (char_q)
				mon_char_pkg::CH_GO:    info.cmd = mon_char_pkg::CMD_GO;
				mon_char_pkg::CH_QUIT:  info.cmd = mon_char_pkg::CMD_QUIT;
				mon_char_pkg::CH_WRITE: info.cmd = mon_char_pkg::CMD_WRITE;
				mon_char_pkg::CH_READ:  info.cmd = mon_char_pkg::CMD_READ;
				mon_char_pkg::CH_TRASH: info.cmd = mon_char_pkg::CMD_TRASH;
				mon_char_pkg::CH_PC:    info.cmd = mon_char_pkg::CMD_PC;
				mon_char_pkg::CH_CR:    info.cmd = mon_char_pkg::CMD_CR;
				// anything else, uppercase hex included
				default:                info.cmd = mon_char_pkg::CMD_NONE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/mon_cmd_pkg.sv
// command-side types for the monitor; words are fixed at 32 bits, eight hex digits each
`default_nettype none

package mon_cmd_pkg;

	// assembled address or data word
	typedef logic [31:0] word_t;

	// hex digits per word
	localparam int WORD_DIGITS = 8;

	// command state machine
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_GO_ADDR,
		ST_GO_RUN,
		ST_WR_ADDR,
		ST_WR_DATA,
		ST_RD_START,
		ST_RD_END,
		ST_RD_DUMP,
		ST_TRASH,
		ST_PC_PRINT
	} cmd_state_e;

	// busy levels held by the control logic
	typedef struct packed {
		logic dump_running;
		logic trush_running;
	} ctrl_status_t;

	// strobes and levels to the control logic
	typedef struct packed {
		logic write_address_set;
		logic write_data_en;
		logic read_start_set;
		logic read_end_set;
		logic read_stop;
		logic start_trush;
		logic quit_cmd;
		logic pc_print;
		logic pc_print_sel;
		logic crlf_in;
		logic cpu_start;
	} mon_strobes_t;

endpackage

`default_nettype wire

// File: verilog/mon_char_pkg.sv
// received-byte types for the monitor; only lowercase hex digits are accepted, uppercase is not
`default_nettype none

package mon_char_pkg;

	// one byte as delivered by the uart receiver
	typedef logic [7:0] char_t;

	// value of a single hex digit
	typedef logic [3:0] nibble_t;

	// kinds of command characters
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_GO,
		CMD_QUIT,
		CMD_WRITE,
		CMD_READ,
		CMD_TRASH,
		CMD_PC,
		CMD_CR
	} cmd_char_e;

	// decoded character, valid for one cycle
	typedef struct packed {
		logic       valid;
		logic       is_digit;
		nibble_t    nibble;
		cmd_char_e  cmd;
	} char_info_t;

	// hex digit ranges
	localparam char_t CH_DIGIT_0 = 8'h30;
	localparam char_t CH_DIGIT_9 = 8'h39;
	localparam char_t CH_HEX_A   = 8'h61;
	localparam char_t CH_HEX_F   = 8'h66;

	// command letters
	localparam char_t CH_GO    = 8'h67;
	localparam char_t CH_QUIT  = 8'h71;
	localparam char_t CH_WRITE = 8'h77;
	localparam char_t CH_READ  = 8'h72;
	localparam char_t CH_TRASH = 8'h74;
	localparam char_t CH_PC    = 8'h6a;
	// carriage return, answered with a line feed
	localparam char_t CH_CR    = 8'h0d;

endpackage

`default_nettype wire
